// File: sim/life_assertions.sv
/* Serial line and strobe assertions */

`timescale 1ns/1ps

module life_assertions (
  input logic            clk,
  input logic            boot_reset,
  input logic            uart_tx_line,
  input life_pkg::char_t tx_data,
  input logic            tx_valid,
  input logic            tx_ready,
  input logic            rand_start,
  input logic            step_start,
  input logic            show_start,
  input logic            board_done
);

  int unsigned failures = 0;  // failed assertions so far

  // line idles high through reset and the cycle after
  line_high_in_reset: assert property (@(posedge clk) boot_reset |=> uart_tx_line)
    else begin
      $error("uart_tx_line low during or right after reset");
      failures++;
    end

  // a byte waiting for the transmitter must not move
  tx_byte_held: assert property (@(posedge clk) disable iff (boot_reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else begin
      $error("tx_data or tx_valid changed before the byte was accepted");
      failures++;
    end

  starts_exclusive: assert property (@(posedge clk) disable iff (boot_reset)
    $onehot0({rand_start, step_start, show_start}))
    else begin
      $error("more than one of rand_start, step_start, show_start high");
      failures++;
    end

  // every finished board operation is shown
  show_after_board: assert property (@(posedge clk) disable iff (boot_reset)
    board_done |=> show_start)
    else begin
      $error("show_start did not follow board_done");
      failures++;
    end

endmodule

// File: sim/life_tb.sv
/* Game of Life testbench */

`timescale 1ns/1ps

module life_tb;

  localparam int CLK_NS = 20;
  localparam int CLOCK_RATE = 50_000_000;
  localparam int BAUD_RATE = 1_000_000;
  localparam int UPDATE_INTERVAL = 3000;
  localparam int CLKS_PER_BIT = CLOCK_RATE / BAUD_RATE;
  localparam int BIT_NS = CLKS_PER_BIT * CLK_NS;
  localparam int FRAME_LEN = 84;  // home, then 8 rows of 8 cells and CR LF
  localparam int FRAME_NS = FRAME_LEN * 10 * BIT_NS;
  localparam int INTERVAL_NS = UPDATE_INTERVAL * CLK_NS;
  localparam int STEP_NS = 641 * CLK_NS;
  localparam int FRAME_WAIT_CLKS = 2 * (FRAME_NS + INTERVAL_NS + STEP_NS) / CLK_NS;
  localparam int QUIET_CLKS = 10_000;
  localparam int STOP_QUIET_CLKS = (4 * INTERVAL_NS + FRAME_NS) / CLK_NS;
  localparam int WATCHDOG_NS = 30 * FRAME_NS;  // about a dozen frames, doubled

  localparam logic [7:0] KEY_RANDOMIZE = 8'h30;  // '0'
  localparam logic [7:0] KEY_STEP = 8'h31;       // '1'
  localparam logic [7:0] KEY_RUN = 8'h20;        // space
  localparam logic [7:0] KEY_OTHER = 8'h78;      // 'x'
  localparam logic [7:0] BYTE_ALIVE = 8'h4f;
  localparam logic [7:0] BYTE_DEAD = 8'h20;
  localparam logic [7:0] BYTE_CR = 8'h0d;
  localparam logic [7:0] BYTE_LF = 8'h0a;

  logic clk = 1'b0;
  logic boot_reset;
  logic uart_rx_line;
  wire  uart_tx_line;

  int seed;
  int errors = 0;
  int byte_count = 0;
  int frame_count = 0;
  int frame_pos = 0;
  logic [63:0] frame_board;
  logic [63:0] boards[$];  // one decoded board per frame

  always #(CLK_NS / 2) clk = ~clk;

  life_top #(
    .CLOCK_RATE(CLOCK_RATE),
    .BAUD_RATE(BAUD_RATE),
    .UPDATE_INTERVAL(UPDATE_INTERVAL)
  ) life_top_inst (
    .clk(clk),
    .boot_reset(boot_reset),
    .uart_rx_line(uart_rx_line),
    .uart_tx_line(uart_tx_line)
  );

  bind life_top life_assertions life_assertions_inst (
    .clk(clk),
    .boot_reset(boot_reset),
    .uart_tx_line(uart_tx_line),
    .tx_data(tx_data),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .rand_start(rand_start),
    .step_start(step_start),
    .show_start(show_start),
    .board_done(board_done)
  );

  // toroidal Life rule, bit row*8+col
  function automatic logic [63:0] life_successor(input logic [63:0] b);
    logic [63:0] n;
    int r, c, dr, dc, cnt;
    n = '0;
    for (r = 0; r < 8; r++) begin
      for (c = 0; c < 8; c++) begin
        cnt = 0;
        for (dr = -1; dr <= 1; dr++) begin
          for (dc = -1; dc <= 1; dc++) begin
            if (dr != 0 || dc != 0) cnt += b[((r + dr + 8) % 8) * 8 + (c + dc + 8) % 8];
          end
        end
        n[r * 8 + c] = (cnt == 3) || (b[r * 8 + c] && cnt == 2);
      end
    end
    return n;
  endfunction

  function automatic logic [7:0] home_byte(input int pos);
    case (pos)
      0: return 8'h1b;  // ESC
      1: return 8'h5b;
      2: return 8'h3b;
      default: return 8'h48;
    endcase
  endfunction

  task automatic note_stray(input logic [7:0] b, input logic [7:0] expected);
    $display("out-of-place byte %h at position %0d of frame %0d (wanted %h) at %0t ns",
             b, frame_pos, frame_count, expected, $time);
    errors++;
  endtask

  // place one received byte into the frame being rebuilt
  task automatic take_byte(input logic [7:0] b);
    int p;
    p = frame_pos - 4;
    byte_count++;
    if (frame_pos < 4) begin
      if (b !== home_byte(frame_pos)) note_stray(b, home_byte(frame_pos));
    end else if (p % 10 < 8) begin
      if (b === BYTE_ALIVE) frame_board[(p / 10) * 8 + p % 10] = 1'b1;
      else if (b === BYTE_DEAD) frame_board[(p / 10) * 8 + p % 10] = 1'b0;
      else note_stray(b, BYTE_DEAD);
    end else if (p % 10 == 8) begin
      if (b !== BYTE_CR) note_stray(b, BYTE_CR);
    end else if (b !== BYTE_LF) begin
      note_stray(b, BYTE_LF);
    end
    if (frame_pos == FRAME_LEN - 1) begin
      boards.push_back(frame_board);
      frame_count++;
      frame_pos = 0;
    end else begin
      frame_pos++;
    end
  endtask

  // mid-bit sampling, kept off the clock edges
  initial begin : serial_decoder
    logic [7:0] b;
    int i;
    forever begin
      @(negedge uart_tx_line);
      #(BIT_NS / 2 + 10);
      if (uart_tx_line !== 1'b0) begin
        $display("start bit on uart_tx_line did not stay low at %0t ns", $time);
        errors++;
      end else begin
        for (i = 0; i < 8; i++) begin
          #(BIT_NS);
          b[i] = uart_tx_line;  // lsb first
        end
        #(BIT_NS);
        if (uart_tx_line !== 1'b1) begin
          $display("missing stop bit on uart_tx_line at %0t ns", $time);
          errors++;
        end else begin
          take_byte(b);
        end
      end
    end
  end

  task automatic send_byte(input logic [7:0] b);
    int i;
    @(posedge clk);
    #2 uart_rx_line = 1'b0;  // start bit
    for (i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      #2 uart_rx_line = b[i];
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    #2 uart_rx_line = 1'b1;
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic random_gap();
    int n;
    n = $unsigned($random(seed)) % 200;
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_for_frames(input int target);
    int waited;
    waited = 0;
    while (frame_count < target && waited < FRAME_WAIT_CLKS) begin
      @(posedge clk);
      waited++;
    end
    if (frame_count < target) begin
      $display("frame %0d never arrived, waited %0d clocks", target, FRAME_WAIT_CLKS);
      errors++;
    end
  endtask

  task automatic wait_for_bytes(input int target);
    int waited;
    waited = 0;
    while (byte_count < target && waited < FRAME_WAIT_CLKS) begin
      @(posedge clk);
      waited++;
    end
    if (byte_count < target) begin
      $display("no frame started printing within %0d clocks", FRAME_WAIT_CLKS);
      errors++;
    end
  endtask

  task automatic expect_quiet(input int clks, input string what);
    int start;
    start = byte_count;
    repeat (clks) @(posedge clk);
    if (byte_count != start) begin
      $display("%0d unexpected bytes on uart_tx_line %s", byte_count - start, what);
      errors++;
    end
  endtask

  task automatic check_successor(input int idx);
    logic [63:0] expected;
    if (boards.size() > idx) begin
      expected = life_successor(boards[idx - 1]);
      if (boards[idx] !== expected) begin
        $display("error at %0t ns: frame %0d board expected %h got %h",
                 $time, idx, expected, boards[idx]);
        errors++;
      end
    end
  endtask

  task automatic report_and_finish(input bit timed_out);
    int failed;
    failed = errors + life_top_inst.life_assertions_inst.failures;
    $display("frames %0d, testbench errors %0d, assertion failures %0d", frame_count,
             errors, life_top_inst.life_assertions_inst.failures);
    if (failed == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    report_and_finish(1'b1);
  end

  initial begin : stimulus
    seed = 32'h6b25;
    boot_reset = 1'b1;
    uart_rx_line = 1'b1;
    repeat (8) @(posedge clk);
    #2 boot_reset = 1'b0;

    // silent until the first byte, then a single frame
    expect_quiet(QUIET_CLKS, "before the first command");
    send_byte(KEY_STEP);
    wait_for_frames(1);
    expect_quiet(QUIET_CLKS / 2, "after the first frame");

    random_gap();
    send_byte(KEY_STEP);
    wait_for_frames(2);
    check_successor(1);

    random_gap();
    send_byte(KEY_RANDOMIZE);
    wait_for_frames(3);
    random_gap();
    send_byte(KEY_STEP);
    wait_for_frames(4);
    check_successor(3);

    // ignored bytes
    random_gap();
    send_byte(KEY_OTHER);
    expect_quiet(QUIET_CLKS, "after an unknown byte");
    random_gap();
    send_byte(KEY_STEP);
    wait_for_bytes(byte_count + 1);
    send_byte(KEY_STEP);  // lands while the frame prints
    wait_for_frames(5);
    check_successor(4);
    expect_quiet(QUIET_CLKS, "after a step sent during printing");

    // automatic stepping, then stop inside the idle window
    random_gap();
    send_byte(KEY_RUN);
    wait_for_frames(6);
    wait_for_frames(7);
    wait_for_frames(8);
    random_gap();
    send_byte(KEY_STEP);
    check_successor(5);
    check_successor(6);
    check_successor(7);
    expect_quiet(STOP_QUIET_CLKS, "after automatic stepping was stopped");

    report_and_finish(1'b0);
  end

endmodule

// File: sources.f
src/life_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/life_control.sv
src/life_board.sv
src/board_display.sv
src/life_top.sv
sim/life_assertions.sv
sim/life_tb.sv

// File: src/board_display.sv
/* Board frame printer */

`timescale 1ns/1ps

module board_display (
  input  logic                  clk,
  input  logic                  boot_reset,
  input  logic                  show_start,
  input  logic                  cell_rd_value,
  input  logic                  tx_ready,
  output life_pkg::cell_index_t cell_rd_index,
  output life_pkg::char_t       tx_data,
  output logic                  tx_valid,
  output logic                  show_done
);

  import life_pkg::*;

  localparam logic [1:0] D_IDLE = 2'd0, D_HOME = 2'd1, D_BODY = 2'd2;

  // column positions past the cells carry the line end
  localparam logic [LOG_WIDTH:0] COL_CR = (LOG_WIDTH+1)'(BOARD_WIDTH);
  localparam logic [LOG_WIDTH:0] COL_LF = (LOG_WIDTH+1)'(BOARD_WIDTH + 1);
  localparam logic [LOG_HEIGHT-1:0] ROW_LAST = LOG_HEIGHT'(BOARD_HEIGHT - 1);

  logic [1:0]            phase;
  logic [1:0]            home_pos;
  logic [LOG_HEIGHT-1:0] row;
  logic [LOG_WIDTH:0]    col;

  wire accept = tx_valid && tx_ready;

  always_comb begin
    cell_rd_index.rc.row = row;
    cell_rd_index.rc.col = col[LOG_WIDTH-1:0];
  end

  // byte for the current position, stable until the counters move
  always_comb begin
    tx_data = CHAR_DEAD;
    case (phase)
      D_HOME: begin
        case (home_pos)
          2'd0: tx_data = CHAR_ESC;
          2'd1: tx_data = CHAR_LBRACKET;
          2'd2: tx_data = CHAR_SEMI;
          default: tx_data = CHAR_HOME_H;
        endcase
      end
      D_BODY: begin
        if (!col[LOG_WIDTH]) tx_data = cell_rd_value ? CHAR_ALIVE : CHAR_DEAD;
        else if (col == COL_CR) tx_data = CHAR_CR;
        else tx_data = CHAR_LF;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      phase <= D_IDLE;
      home_pos <= '0;
      row <= '0;
      col <= '0;
      tx_valid <= 1'b0;
      show_done <= 1'b0;
    end else begin
      show_done <= 1'b0;
      case (phase)
        D_IDLE: begin
          if (show_start) begin
            phase <= D_HOME;
            home_pos <= '0;
            tx_valid <= 1'b1;
          end
        end
        D_HOME: begin
          if (accept) begin
            home_pos <= home_pos + 1'b1;
            if (home_pos == 2'd3) begin
              phase <= D_BODY;
              row <= '0;
              col <= '0;
            end
          end
        end
        D_BODY: begin
          if (accept) begin
            if (col == COL_LF) begin  // row finished
              col <= '0;
              row <= row + 1'b1;
              if (row == ROW_LAST) begin
                phase <= D_IDLE;
                tx_valid <= 1'b0;
                show_done <= 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        default: phase <= D_IDLE;
      endcase
    end
  end

endmodule

// File: src/life_board.sv
/* Life board engine */

`timescale 1ns/1ps

module life_board (
  input  logic                  clk,
  input  logic                  boot_reset,
  input  logic                  rand_start,
  input  logic                  step_start,
  input  life_pkg::cell_index_t cell_rd_index,
  output logic                  cell_rd_value,
  output logic                  board_done
);

  import life_pkg::*;

  localparam int IDX_W = $bits(cell_index_t);
  localparam logic [IDX_W-1:0] LAST_CELL = IDX_W'(BOARD_SIZE - 1);

  localparam logic [1:0] B_IDLE = 2'd0, B_FILL = 2'd1, B_COUNT = 2'd2, B_COPY = 2'd3;

  logic [BOARD_SIZE-1:0] cur_board;
  logic [BOARD_SIZE-1:0] next_board;
  logic [15:0]           lfsr;

  logic [1:0]      state;
  cell_index_t     idx;      // cell being filled, counted or copied
  cell_index_t     nbr;      // neighbour currently read
  logic [3:0]      nbr_sel;  // 0..7 neighbours, 8 applies the rule
  logic [3:0]      nbr_sum;
  logic [LOG_HEIGHT-1:0] drow;
  logic [LOG_WIDTH-1:0]  dcol;
  logic            next_alive;

  assign cell_rd_value = cur_board[cell_rd_index.flat];

  // x^16 + x^14 + x^13 + x^11 + 1, free running
  always_ff @(posedge clk) begin
    if (boot_reset) begin
      lfsr <= 16'hace1;
    end else begin
      lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end
  end

  // neighbour offsets, all ones is -1 and wraps the torus
  always_comb begin
    case (nbr_sel[2:0])
      3'd0: begin drow = '1; dcol = '1; end
      3'd1: begin drow = '1; dcol = '0; end
      3'd2: begin drow = '1; dcol = 1;  end
      3'd3: begin drow = '0; dcol = '1; end
      3'd4: begin drow = '0; dcol = 1;  end
      3'd5: begin drow = 1;  dcol = '1; end
      3'd6: begin drow = 1;  dcol = '0; end
      default: begin drow = 1; dcol = 1; end
    endcase
    nbr.rc.row = idx.rc.row + drow;  // modulo 8 by width
    nbr.rc.col = idx.rc.col + dcol;
  end

  assign next_alive = (nbr_sum == 4'd3) || (cur_board[idx.flat] && nbr_sum == 4'd2);

  always_ff @(posedge clk) begin
    case (state)
      B_FILL:  cur_board[idx.flat] <= lfsr[0];
      B_COUNT: if (nbr_sel[3]) next_board[idx.flat] <= next_alive;
      B_COPY:  cur_board[idx.flat] <= next_board[idx.flat];
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state <= B_IDLE;
      idx <= '0;
      nbr_sel <= '0;
      nbr_sum <= '0;
      board_done <= 1'b0;
    end else begin
      board_done <= 1'b0;
      case (state)
        B_IDLE: begin
          idx <= '0;
          nbr_sel <= '0;
          nbr_sum <= '0;
          if (rand_start) state <= B_FILL;
          else if (step_start) state <= B_COUNT;
        end
        B_FILL, B_COPY: begin
          idx.flat <= idx.flat + 1'b1;
          if (idx.flat == LAST_CELL) begin
            board_done <= 1'b1;
            state <= B_IDLE;
          end
        end
        B_COUNT: begin
          if (!nbr_sel[3]) begin  // one neighbour per clock
            nbr_sum <= nbr_sum + {3'b000, cur_board[nbr.flat]};
            nbr_sel <= nbr_sel + 1'b1;
          end else begin
            nbr_sel <= '0;
            nbr_sum <= '0;
            idx.flat <= idx.flat + 1'b1;
            if (idx.flat == LAST_CELL) state <= B_COPY;  // idx wraps to 0
          end
        end
        default: state <= B_IDLE;
      endcase
    end
  end

endmodule

// File: src/life_control.sv
/* Command decoder and run control */

`timescale 1ns/1ps

module life_control #(
  parameter int UPDATE_INTERVAL = 10_000_000
) (
  input  logic             clk,
  input  logic             boot_reset,
  input  life_pkg::char_t  rx_data,
  input  logic             rx_valid,
  input  logic             board_done,
  input  logic             show_done,
  output logic             rand_start,
  output logic             step_start,
  output logic             show_start
);

  import life_pkg::*;

  localparam int TIMER_W = $clog2(UPDATE_INTERVAL + 1);
  localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(UPDATE_INTERVAL - 1);

  localparam logic [2:0] S_WAIT_FIRST = 3'd0;
  localparam logic [2:0] S_RANDOMIZE  = 3'd1;
  localparam logic [2:0] S_STEP       = 3'd2;
  localparam logic [2:0] S_SHOW       = 3'd3;
  localparam logic [2:0] S_IDLE       = 3'd4;

  logic [2:0]         state;
  logic               running;  // automatic stepping enabled
  logic [TIMER_W-1:0] timer;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state <= S_WAIT_FIRST;
      running <= 1'b0;
      timer <= '0;
      rand_start <= 1'b0;
      step_start <= 1'b0;
      show_start <= 1'b0;
    end else begin
      rand_start <= 1'b0;
      step_start <= 1'b0;
      show_start <= 1'b0;
      case (state)
        S_WAIT_FIRST: begin
          if (rx_valid) begin  // any byte kicks off the first board
            rand_start <= 1'b1;
            state <= S_RANDOMIZE;
          end
        end
        S_RANDOMIZE, S_STEP: begin
          if (board_done) begin  // every board change is followed by a frame
            show_start <= 1'b1;
            state <= S_SHOW;
          end
        end
        S_SHOW: begin
          if (show_done) state <= S_IDLE;
        end
        S_IDLE: begin
          if (rx_valid) begin
            case (rx_data)
              CMD_RANDOMIZE: begin
                rand_start <= 1'b1;
                state <= S_RANDOMIZE;
              end
              CMD_STEP: begin
                if (running) begin  // '1' doubles as stop
                  running <= 1'b0;
                  timer <= '0;
                end else begin
                  step_start <= 1'b1;
                  state <= S_STEP;
                end
              end
              CMD_RUN_TOGGLE: begin
                running <= ~running;
                timer <= '0;
              end
              default: ;  // unknown byte
            endcase
          end else if (running) begin
            if (timer == TIMER_LAST) begin
              timer <= '0;
              step_start <= 1'b1;
              state <= S_STEP;
            end else begin
              timer <= timer + 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: src/life_pkg.sv
/* Game of Life shared definitions */

package life_pkg;

  // board geometry, 8x8 torus
  localparam int LOG_WIDTH = 3;
  localparam int LOG_HEIGHT = 3;
  localparam int BOARD_WIDTH = 2 ** LOG_WIDTH;
  localparam int BOARD_HEIGHT = 2 ** LOG_HEIGHT;
  localparam int BOARD_SIZE = BOARD_WIDTH * BOARD_HEIGHT;

  // one cell number, seen flat for storage or as row/col for wrapping
  typedef union packed {
    logic [LOG_WIDTH+LOG_HEIGHT-1:0] flat;
    struct packed {
      logic [LOG_HEIGHT-1:0] row;  // upper bits
      logic [LOG_WIDTH-1:0]  col;  // lower bits
    } rc;
  } cell_index_t;

  typedef logic [7:0] char_t;

  localparam char_t CHAR_ALIVE    = 8'h4f;  // 'O'
  localparam char_t CHAR_DEAD     = 8'h20;  // space
  localparam char_t CHAR_ESC      = 8'h1b;
  localparam char_t CHAR_LBRACKET = 8'h5b;  // '['
  localparam char_t CHAR_SEMI     = 8'h3b;  // ';'
  localparam char_t CHAR_HOME_H   = 8'h48;  // 'H'
  localparam char_t CHAR_CR       = 8'h0d;
  localparam char_t CHAR_LF       = 8'h0a;

  localparam char_t CMD_RANDOMIZE  = 8'h30;  // '0'
  localparam char_t CMD_STEP       = 8'h31;  // '1'
  localparam char_t CMD_RUN_TOGGLE = 8'h20;  // space

endpackage

// File: src/life_top.sv
/* Game of Life over UART */

`timescale 1ns/1ps

module life_top #(
  parameter int CLOCK_RATE      = 50_000_000,
  parameter int BAUD_RATE       = 115_200,
  parameter int UPDATE_INTERVAL = CLOCK_RATE / 5  // 5 generations per second
) (
  input  logic clk,
  input  logic boot_reset,
  input  logic uart_rx_line,
  output logic uart_tx_line
);

  import life_pkg::*;

  char_t       rx_data;
  logic        rx_valid;
  char_t       tx_data;
  logic        tx_valid;
  logic        tx_ready;
  logic        rand_start;
  logic        step_start;
  logic        show_start;
  logic        board_done;
  logic        show_done;
  cell_index_t cell_rd_index;
  logic        cell_rd_value;

  uart_rx #(
    .CLOCK_RATE(CLOCK_RATE),
    .BAUD_RATE(BAUD_RATE)
  ) uart_rx_inst (
    .clk(clk),
    .boot_reset(boot_reset),
    .uart_rx_line(uart_rx_line),
    .rx_data(rx_data),
    .rx_valid(rx_valid)
  );

  uart_tx #(
    .CLOCK_RATE(CLOCK_RATE),
    .BAUD_RATE(BAUD_RATE)
  ) uart_tx_inst (
    .clk(clk),
    .boot_reset(boot_reset),
    .tx_data(tx_data),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .uart_tx_line(uart_tx_line)
  );

  life_control #(
    .UPDATE_INTERVAL(UPDATE_INTERVAL)
  ) life_control_inst (
    .clk(clk),
    .boot_reset(boot_reset),
    .rx_data(rx_data),
    .rx_valid(rx_valid),
    .board_done(board_done),
    .show_done(show_done),
    .rand_start(rand_start),
    .step_start(step_start),
    .show_start(show_start)
  );

  life_board life_board_inst (
    .clk(clk),
    .boot_reset(boot_reset),
    .rand_start(rand_start),
    .step_start(step_start),
    .cell_rd_index(cell_rd_index),
    .cell_rd_value(cell_rd_value),
    .board_done(board_done)
  );

  board_display board_display_inst (
    .clk(clk),
    .boot_reset(boot_reset),
    .show_start(show_start),
    .cell_rd_value(cell_rd_value),
    .tx_ready(tx_ready),
    .cell_rd_index(cell_rd_index),
    .tx_data(tx_data),
    .tx_valid(tx_valid),
    .show_done(show_done)
  );

endmodule

// File: src/uart_rx.sv
/* UART receiver, 8N1 */

`timescale 1ns/1ps

module uart_rx #(
  parameter int CLOCK_RATE = 50_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic             clk,
  input  logic             boot_reset,
  input  logic             uart_rx_line,
  output life_pkg::char_t  rx_data,
  output logic             rx_valid
);

  localparam int CLKS_PER_BIT = CLOCK_RATE / BAUD_RATE;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] R_IDLE = 2'd0, R_START = 2'd1, R_DATA = 2'd2, R_STOP = 2'd3;

  logic [1:0]       state;
  logic [1:0]       line_sync;  // two-flop synchronizer
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;

  wire line_in = line_sync[1];

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      line_sync <= 2'b11;
    end else begin
      line_sync <= {line_sync[0], uart_rx_line};
    end
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state <= R_IDLE;
      cnt <= '0;
      bit_idx <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        R_IDLE: begin
          cnt <= '0;
          if (!line_in) state <= R_START;  // falling edge of start bit
        end
        R_START: begin
          if (cnt == CNT_HALF) begin
            cnt <= '0;
            bit_idx <= '0;
            state <= line_in ? R_IDLE : R_DATA;  // glitch, not a start bit
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        R_DATA: begin
          if (cnt == CNT_LAST) begin
            cnt <= '0;
            shift <= {line_in, shift[7:1]};  // lsb first
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= R_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (cnt == CNT_LAST) begin
            state <= R_IDLE;
            if (line_in) begin
              rx_data <= shift;
              rx_valid <= 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

// File: src/uart_tx.sv
/* UART transmitter, 8N1 */

`timescale 1ns/1ps

module uart_tx #(
  parameter int CLOCK_RATE = 50_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic             clk,
  input  logic             boot_reset,
  input  life_pkg::char_t  tx_data,
  input  logic             tx_valid,
  output logic             tx_ready,
  output logic             uart_tx_line
);

  localparam int CLKS_PER_BIT = CLOCK_RATE / BAUD_RATE;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  localparam logic [1:0] T_IDLE = 2'd0, T_START = 2'd1, T_DATA = 2'd2, T_STOP = 2'd3;

  logic [1:0]       state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;

  assign tx_ready = (state == T_IDLE);

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state <= T_IDLE;
      cnt <= '0;
      bit_idx <= '0;
      uart_tx_line <= 1'b1;  // line idles high
    end else begin
      case (state)
        T_IDLE: begin
          cnt <= '0;
          if (tx_valid) begin
            shift <= tx_data;
            uart_tx_line <= 1'b0;  // start bit
            state <= T_START;
          end
        end
        T_START, T_DATA: begin
          if (cnt == CNT_LAST) begin
            cnt <= '0;
            if (state == T_DATA && bit_idx == 3'd7) begin
              uart_tx_line <= 1'b1;  // stop bit
              state <= T_STOP;
            end else begin
              uart_tx_line <= shift[0];
              shift <= {1'b1, shift[7:1]};
              bit_idx <= (state == T_START) ? 3'd0 : bit_idx + 1'b1;
              state <= T_DATA;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (cnt == CNT_LAST) state <= T_IDLE;
          else cnt <= cnt + 1'b1;
        end
      endcase
    end
  end

endmodule
